// File: mmu_top.f
hw/mmu_pkg.sv
hw/tlb_lookup_if.sv
hw/tlb_array.sv
hw/addr_translate.sv
hw/tlb_maint.sv
hw/mmu_top.sv
tests/clk_gen.sv
tests/mmu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mmu_tb
FILELIST  ?= mmu_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: tests/mmu_tb.sv
`timescale 1ns/1ps

module mmu_tb
    import mmu_pkg::*;
();

    typedef struct packed {
        logic [31:0] paddr;
        tlb_exc_t    exc;
        logic        cached;
        logic        uncached;
    } xlate_t;

    localparam int wait_limit = 20;

    logic clk, rst_n;
    logic inst_req_valid, inst_req_ready, inst_res_valid, inst_res_ready;
    logic data_req_valid, data_req_ready, data_res_valid, data_res_ready, data_wr;
    logic [31:0] inst_vaddr, inst_paddr, data_vaddr, data_paddr;
    logic [asid_w-1:0] inst_asid, data_asid;
    tlb_exc_t inst_exc, data_exc;
    logic inst_cached, inst_uncached, data_cached, data_uncached;
    logic cmd_valid, cmd_ready, done;
    tlb_cmd_t cmd;
    tlb_regs_t cmd_regs, res_regs;

    // reference copy of the TLB with images as tlbr returns them
    logic [31:0] m_hi [int];
    logic [31:0] m_lo0 [int];
    logic [31:0] m_lo1 [int];
    xlate_t inst_q [$];
    xlate_t data_q [$];

    int seed = 44423;
    int errors, err_mark, tests_run, tests_passed, base;
    int exp_idx, slot, accept_edge, edge_count;
    int test_cycles [6] = '{10, 40, 70, 20, 20, 25};
    int idx [4];
    logic [vpn2_w-1:0] vpn [4];
    logic [asid_w-1:0] asids [4];
    // {d, v} of each page and the two g bits for entry k
    logic [1:0] dv0 [4] = '{2'b11, 2'b11, 2'b10, 2'b11};
    logic [1:0] dv1 [4] = '{2'b11, 2'b11, 2'b01, 2'b11};
    logic gl0 [4] = '{1'b1, 1'b1, 1'b0, 1'b0};
    logic gl1 [4] = '{1'b1, 1'b0, 1'b0, 1'b1};
    logic [31:0] va;
    tlb_regs_t regs, res;

    clk_gen u_clk (.clk, .rst_n);

    mmu_top DUT (.*);

    done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_valid && cmd_ready) |=> done)
        else begin errors++; $display("done did not follow an accepted command"); end
    cmd_gap: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_ready != done)
        else begin errors++; $display("cmd_ready was not low exactly while done was high"); end
    inst_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (inst_req_valid && inst_req_ready) |=> inst_res_valid)
        else begin errors++; $display("inst result late after accept"); end
    data_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (data_req_valid && data_req_ready) |=> data_res_valid)
        else begin errors++; $display("data result late after accept"); end
    data_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (data_res_valid && !data_res_ready) |=> (data_res_valid && $stable(data_paddr)
        && $stable(data_exc) && $stable(data_cached) && $stable(data_uncached)))
        else begin errors++; $display("data result changed while stalled"); end
    data_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (data_res_valid && !data_res_ready) |-> !data_req_ready)
        else begin errors++; $display("data port took a request while stalled"); end

    // clock edges since reset, used to follow the random index
    always @(posedge clk) begin
        if (rst_n) begin
            edge_count <= edge_count + 1;
        end
    end

    // lowest matching index or -1 on a miss
    function automatic int lookup_index(logic [vpn2_w-1:0] v2, logic [asid_w-1:0] id);
        for (int i = 0; i < tlb_entries; i++) begin
            if (m_hi[i][31:13] == v2 && (m_lo0[i][0] || m_hi[i][7:0] == id)) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic xlate_t predict(logic [31:0] a, logic [asid_w-1:0] id, logic st);
        xlate_t r;
        int i;
        logic [31:0] lo;
        r = '0;
        if (a[31:29] == 3'b100) begin
            r.paddr = a - 32'h8000_0000;
            r.cached = 1'b1;
        end else if (a[31:29] == 3'b101) begin
            r.paddr = a - 32'hA000_0000;
            r.uncached = 1'b1;
        end else begin
            i = lookup_index(a[31:13], id);
            lo = (i < 0) ? 32'h0 : (a[12] ? m_lo1[i] : m_lo0[i]);
            if (i < 0) begin
                r.exc = st ? refill_s : refill_l;
            end else if (!lo[1]) begin
                r.exc = st ? invalid_s : invalid_l;
            end else if (st && !lo[2]) begin
                r.exc = modified;
            end else begin
                r.paddr = {lo[25:6], a[11:0]};
                r.cached = (lo[5:3] == 3'd3);
                r.uncached = !r.cached;
            end
        end
        return r;
    endfunction

    task automatic remember(input int i, input tlb_regs_t r);
        logic g;
        g = r.entrylo0[0] & r.entrylo1[0];
        m_hi[i] = r.entryhi;
        m_lo0[i] = {r.entrylo0[31:1], g};
        m_lo1[i] = {r.entrylo1[31:1], g};
    endtask

    task automatic compare(input string port, input logic [31:0] pa, input tlb_exc_t ex,
                           input logic ca, input logic un, input xlate_t e);
        assert (ex == e.exc)
            else begin errors++; $display("error %s_exc: got %h expected %h", port, ex, e.exc); end
        if (e.exc == no_exc) begin
            assert (pa == e.paddr) else begin
                errors++;
                $display("error %s_paddr: got %h expected %h", port, pa, e.paddr);
            end
            assert (ca == e.cached) else begin
                errors++;
                $display("error %s_cached: got %h expected %h", port, ca, e.cached);
            end
            assert (un == e.uncached) else begin
                errors++;
                $display("error %s_uncached: got %h expected %h", port, un, e.uncached);
            end
        end
    endtask

    // results are checked in the order the requests were accepted
    always @(posedge clk) begin
        if (rst_n && inst_res_valid && inst_res_ready) begin
            if (inst_q.size() == 0) begin
                errors++;
                $display("inst port returned a result with no request");
            end else begin
                compare("inst", inst_paddr, inst_exc, inst_cached, inst_uncached,
                        inst_q.pop_front());
            end
        end
        if (rst_n && data_res_valid && data_res_ready) begin
            if (data_q.size() == 0) begin
                errors++;
                $display("data port returned a result with no request");
            end else begin
                compare("data", data_paddr, data_exc, data_cached, data_uncached,
                        data_q.pop_front());
            end
        end
    end

    task automatic send(input bit on_data, input logic [31:0] a,
                        input logic [asid_w-1:0] id, input logic st);
        int waited;
        waited = 0;
        @(negedge clk);
        if (on_data) begin
            data_req_valid = 1'b1;
            data_vaddr = a;
            data_asid = id;
            data_wr = st;
        end else begin
            inst_req_valid = 1'b1;
            inst_vaddr = a;
            inst_asid = id;
        end
        do begin
            @(posedge clk);
            waited++;
        end while (!(on_data ? data_req_ready : inst_req_ready) && waited < wait_limit);
        if (!(on_data ? data_req_ready : inst_req_ready)) begin
            errors++;
            $display("request to %h was never accepted", a);
        end else if (on_data) begin
            data_q.push_back(predict(a, id, st));
        end else begin
            inst_q.push_back(predict(a, id, 1'b0));
        end
        @(negedge clk);
        if (on_data) begin
            data_req_valid = 1'b0;
        end else begin
            inst_req_valid = 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((inst_q.size() != 0 || data_q.size() != 0) && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (inst_q.size() != 0 || data_q.size() != 0) begin
            errors++;
            $display("translation results still missing at the end of the test");
        end
    endtask

    task automatic run_cmd(input tlb_cmd_t op, input tlb_regs_t r, output tlb_regs_t out);
        int waited;
        waited = 0;
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd = op;
        cmd_regs = r;
        do begin
            @(posedge clk);
            waited++;
        end while (!cmd_ready && waited < wait_limit);
        @(negedge clk);
        cmd_valid = 1'b0;
        accept_edge = edge_count;
        waited = 0;
        while (!done && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            errors++;
            $display("maintenance command %s never finished", op.name());
        end
        out = res_regs;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            tests_passed++;
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        int budget;
        budget = 5;
        foreach (test_cycles[i]) begin
            budget += test_cycles[i];
        end
        repeat (budget * 2) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        inst_req_valid = 1'b0;
        inst_vaddr = '0;
        inst_asid = '0;
        inst_res_ready = 1'b1;
        data_req_valid = 1'b0;
        data_vaddr = '0;
        data_asid = '0;
        data_wr = 1'b0;
        data_res_ready = 1'b1;
        cmd_valid = 1'b0;
        cmd = tlbp;
        cmd_regs = '0;
        for (int i = 0; i < tlb_entries; i++) begin
            remember(i, '0);
        end
        wait (rst_n);
        @(negedge clk);
        assert (!inst_res_valid && !data_res_valid && !done && inst_exc == no_exc
                && data_exc == no_exc)
            else begin errors++; $display("outputs active after reset"); end

        send(0, 32'h8012_3456, 8'h00, 1'b0);
        send(1, 32'hA0AB_CDEF, 8'h00, 1'b1);
        drain();
        end_test("unmapped segments");

        base = $random(seed) & 31;
        for (int k = 0; k < 4; k++) begin
            idx[k] = (base + 7 * k) % tlb_entries;
            vpn[k] = {3'(k), 16'($random(seed))};
            asids[k] = 8'($random(seed));
            regs = '0;
            regs.index = 32'(idx[k]);
            regs.entryhi = {vpn[k], 5'b0, asids[k]};
            regs.entrylo0 = {6'b0, 20'($random(seed)), 3'(k + 2), dv0[k], gl0[k]};
            regs.entrylo1 = {6'b0, 20'($random(seed)), 3'(k + 3), dv1[k], gl1[k]};
            run_cmd(tlbwi, regs, res);
            remember(idx[k], regs);
            run_cmd(tlbr, regs, res);
            assert (res.entryhi == m_hi[idx[k]] && res.entrylo0 == m_lo0[idx[k]]
                    && res.entrylo1 == m_lo1[idx[k]]) else begin
                errors++;
                $display("error res_regs: got %h %h %h expected %h %h %h", res.entryhi,
                         res.entrylo0, res.entrylo1, m_hi[idx[k]], m_lo0[idx[k]], m_lo1[idx[k]]);
            end
        end
        for (int k = 0; k < 5; k++) begin
            regs = '0;
            regs.entryhi = (k < 4) ? {vpn[k], 5'b0, asids[k]} : {3'b111, 16'hbeef, 13'h0};
            exp_idx = lookup_index(regs.entryhi[31:13], regs.entryhi[7:0]);
            run_cmd(tlbp, regs, res);
            if (exp_idx < 0) begin
                assert (res.index[31]) else begin
                    errors++;
                    $display("error res_regs.index[31]: got %h expected 1", res.index[31]);
                end
            end else begin
                assert (res.index == 32'(exp_idx)) else begin
                    errors++;
                    $display("error res_regs.index: got %h expected %h", res.index,
                             32'(exp_idx));
                end
            end
        end
        end_test("write, read and probe");

        for (int k = 0; k < 4; k++) begin
            for (int odd = 0; odd < 2; odd++) begin
                va = {vpn[k], 1'(odd), 12'($random(seed))};
                send(0, va, asids[k], 1'b0);
                send(1, va, asids[k] ^ 8'hff, 1'b0);
                send(1, va, asids[k] ^ 8'hff, 1'b1);
            end
        end
        drain();
        end_test("mapped translation");

        send(1, {vpn[2], 1'b0, 12'h123}, asids[2], 1'b0);
        send(1, {vpn[2], 1'b0, 12'h123}, asids[2], 1'b1);
        send(1, {vpn[2], 1'b1, 12'h456}, asids[2], 1'b1);
        send(0, {vpn[2], 1'b1, 12'h456}, asids[2], 1'b0);
        drain();
        end_test("exceptions");

        @(negedge clk);
        data_res_ready = 1'b0;
        send(1, {vpn[1], 1'b1, 12'h0a4}, asids[1], 1'b0);
        fork
            send(1, {vpn[0], 1'b0, 12'h3c8}, asids[0], 1'b1);
            begin
                repeat (4) @(negedge clk);
                data_res_ready = 1'b1;
            end
        join
        drain();
        end_test("back-pressure");

        regs = '0;
        regs.entryhi = {3'b110, 16'($random(seed)), 5'b0, 8'h5a};
        regs.entrylo0 = {6'b0, 20'($random(seed)), 3'd3, 2'b11, 1'b0};
        regs.entrylo1 = {6'b0, 20'($random(seed)), 3'd2, 2'b11, 1'b0};
        run_cmd(tlbwr, regs, res);
        // the random index stepped down once on every edge before the accepting one
        slot = tlb_entries - 1 - ((accept_edge - 1) % tlb_entries);
        remember(slot, regs);
        run_cmd(tlbp, regs, res);
        assert (res.index == 32'(slot)) else begin
            errors++;
            $display("error res_regs.index: got %h expected %h", res.index, 32'(slot));
        end
        send(1, {regs.entryhi[31:13], 1'b1, 12'h7f0}, 8'h5a, 1'b0);
        send(1, {regs.entryhi[31:13], 1'b0, 12'h010}, 8'h5a, 1'b1);
        send(0, {regs.entryhi[31:13], 1'b0, 12'h020}, 8'h5a, 1'b0);
        drain();
        end_test("random write");

        $display("%0d tests run, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_passed, tests_run - tests_passed, errors);
        if (errors == 0 && tests_passed == tests_run) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: tests/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int half_period  = 50;
    localparam int reset_cycles = 5;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // release on a falling edge away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: hw/mmu_top.sv
`timescale 1ns/1ps

module mmu_top
    import mmu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    input  logic              inst_req_valid,
    input  logic [31:0]       inst_vaddr,
    input  logic [asid_w-1:0] inst_asid,
    output logic              inst_req_ready,
    output logic              inst_res_valid,
    output logic [31:0]       inst_paddr,
    output tlb_exc_t          inst_exc,
    output logic              inst_cached,
    output logic              inst_uncached,
    input  logic              inst_res_ready,

    input  logic              data_req_valid,
    input  logic [31:0]       data_vaddr,
    input  logic [asid_w-1:0] data_asid,
    input  logic              data_wr,
    output logic              data_req_ready,
    output logic              data_res_valid,
    output logic [31:0]       data_paddr,
    output tlb_exc_t          data_exc,
    output logic              data_cached,
    output logic              data_uncached,
    input  logic              data_res_ready,

    input  logic              cmd_valid,
    input  tlb_cmd_t          cmd,
    input  tlb_regs_t         cmd_regs,
    output logic              cmd_ready,
    output logic              done,
    output tlb_regs_t         res_regs
);

    logic                   wr_en;
    logic [tlb_index_w-1:0] wr_index;
    tlb_entry_t             wr_entry;
    logic [tlb_index_w-1:0] rd_index;
    tlb_entry_t             rd_entry;
    logic [vpn2_w-1:0]      probe_vpn2;
    logic [asid_w-1:0]      probe_asid;
    logic                   probe_hit;
    logic [tlb_index_w-1:0] probe_index;

    tlb_lookup_if inst_lk ();
    tlb_lookup_if data_lk ();

    tlb_array u_array (
        .clk, .rst_n,
        .inst_lk     (inst_lk.responder),
        .data_lk     (data_lk.responder),
        .wr_en, .wr_index, .wr_entry,
        .rd_index, .rd_entry,
        .probe_vpn2, .probe_asid, .probe_hit, .probe_index
    );

    // fetch never stores
    addr_translate u_inst (
        .clk, .rst_n,
        .req_valid (inst_req_valid), .vaddr (inst_vaddr), .asid (inst_asid),
        .wr        (1'b0),           .req_ready (inst_req_ready),
        .res_valid (inst_res_valid), .paddr (inst_paddr), .exc (inst_exc),
        .cached    (inst_cached),    .uncached (inst_uncached),
        .res_ready (inst_res_ready), .lk (inst_lk.requester)
    );

    addr_translate u_data (
        .clk, .rst_n,
        .req_valid (data_req_valid), .vaddr (data_vaddr), .asid (data_asid),
        .wr        (data_wr),        .req_ready (data_req_ready),
        .res_valid (data_res_valid), .paddr (data_paddr), .exc (data_exc),
        .cached    (data_cached),    .uncached (data_uncached),
        .res_ready (data_res_ready), .lk (data_lk.requester)
    );

    tlb_maint u_maint (
        .clk, .rst_n,
        .cmd_valid, .cmd, .cmd_regs, .cmd_ready, .done, .res_regs,
        .wr_en, .wr_index, .wr_entry, .rd_index,
        .probe_vpn2, .probe_asid,
        .rd_entry, .probe_hit, .probe_index
    );

endmodule

// File: hw/tlb_maint.sv
`timescale 1ns/1ps

module tlb_maint
    import mmu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   cmd_valid,
    input  tlb_cmd_t               cmd,
    input  tlb_regs_t              cmd_regs,
    output logic                   cmd_ready,
    output logic                   done,
    output tlb_regs_t              res_regs,

    output logic                   wr_en,
    output logic [tlb_index_w-1:0] wr_index,
    output tlb_entry_t             wr_entry,
    output logic [tlb_index_w-1:0] rd_index,
    output logic [vpn2_w-1:0]      probe_vpn2,
    output logic [asid_w-1:0]      probe_asid,
    input  tlb_entry_t             rd_entry,
    input  logic                   probe_hit,
    input  logic [tlb_index_w-1:0] probe_index
);

    logic [tlb_index_w-1:0] rand_idx;
    logic                   accept;
    tlb_regs_t              n_regs;

    // entrylo layout with pfn at 25:6, c at 5:3, d at 2, v at 1 and g at 0
    function automatic logic [31:0] pack_lo(input tlb_page_t pg, input logic g);
        return {6'b0, pg.pfn, pg.c, pg.d, pg.v, g};
    endfunction

    assign cmd_ready = !done;
    assign accept    = cmd_valid && cmd_ready;

    assign wr_en    = accept && (cmd == tlbwi || cmd == tlbwr);
    assign wr_index = (cmd == tlbwr) ? rand_idx : cmd_regs.index[tlb_index_w-1:0];

    assign wr_entry.vpn2  = cmd_regs.entryhi[31:13];
    assign wr_entry.asid  = cmd_regs.entryhi[asid_w-1:0];
    assign wr_entry.g     = cmd_regs.entrylo0[0] & cmd_regs.entrylo1[0];
    assign wr_entry.page0 = {cmd_regs.entrylo0[25:6], cmd_regs.entrylo0[5:3],
                             cmd_regs.entrylo0[2], cmd_regs.entrylo0[1]};
    assign wr_entry.page1 = {cmd_regs.entrylo1[25:6], cmd_regs.entrylo1[5:3],
                             cmd_regs.entrylo1[2], cmd_regs.entrylo1[1]};

    assign rd_index   = cmd_regs.index[tlb_index_w-1:0];
    assign probe_vpn2 = cmd_regs.entryhi[31:13];
    assign probe_asid = cmd_regs.entryhi[asid_w-1:0];

    always_comb begin
        n_regs = cmd_regs;
        case (cmd)
            tlbp: n_regs.index = {!probe_hit, {(31 - tlb_index_w){1'b0}}, probe_index};
            tlbr: begin
                n_regs.entryhi  = {rd_entry.vpn2, 5'b0, rd_entry.asid};
                n_regs.entrylo0 = pack_lo(rd_entry.page0, rd_entry.g);
                n_regs.entrylo1 = pack_lo(rd_entry.page1, rd_entry.g);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rand_idx <= tlb_index_w'(tlb_entries - 1);
            done     <= 1'b0;
        end else begin
            rand_idx <= (rand_idx == '0) ? tlb_index_w'(tlb_entries - 1) : rand_idx - 1'b1;
            done     <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            res_regs <= n_regs;
        end
    end

endmodule

// File: hw/addr_translate.sv
`timescale 1ns/1ps

module addr_translate
    import mmu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    input  logic              req_valid,
    input  logic [31:0]       vaddr,
    input  logic [asid_w-1:0] asid,
    input  logic              wr,
    output logic              req_ready,

    output logic              res_valid,
    output logic [31:0]       paddr,
    output tlb_exc_t          exc,
    output logic              cached,
    output logic              uncached,
    input  logic              res_ready,

    tlb_lookup_if.requester   lk
);

    logic        accept;
    logic        in_kseg0;
    logic        in_kseg1;
    logic [31:0] n_paddr;
    tlb_exc_t    n_exc;
    logic        n_cached;
    logic        n_uncached;

    assign lk.vpn2 = vaddr[31:13];
    assign lk.asid = asid;
    assign lk.odd  = vaddr[12];

    assign in_kseg0 = (vaddr[31:29] == 3'b100);
    assign in_kseg1 = (vaddr[31:29] == 3'b101);

    // one item in flight so the slot frees when the result leaves
    assign req_ready = !res_valid || res_ready;
    assign accept    = req_valid && req_ready;

    always_comb begin
        n_paddr    = {lk.page.pfn, vaddr[11:0]};
        n_exc      = no_exc;
        n_cached   = 1'b0;
        n_uncached = 1'b0;
        if (in_kseg0) begin
            n_paddr  = vaddr - 32'h8000_0000;
            n_cached = 1'b1;
        end else if (in_kseg1) begin
            n_paddr    = vaddr - 32'hA000_0000;
            n_uncached = 1'b1;
        end else if (!lk.hit) begin
            n_exc = wr ? refill_s : refill_l;
        end else if (!lk.page.v) begin
            n_exc = wr ? invalid_s : invalid_l;
        end else if (wr && !lk.page.d) begin
            n_exc = modified;
        end else begin
            // c == 3 is cacheable noncoherent
            n_cached   = (lk.page.c == 3'd3);
            n_uncached = (lk.page.c != 3'd3);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
            exc       <= no_exc;
            cached    <= 1'b0;
            uncached  <= 1'b0;
        end else if (accept) begin
            res_valid <= 1'b1;
            exc       <= n_exc;
            cached    <= n_cached;
            uncached  <= n_uncached;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            paddr <= n_paddr;
        end
    end

endmodule

// File: hw/tlb_array.sv
`timescale 1ns/1ps

module tlb_array
    import mmu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,

    tlb_lookup_if.responder        inst_lk,
    tlb_lookup_if.responder        data_lk,

    input  logic                   wr_en,
    input  logic [tlb_index_w-1:0] wr_index,
    input  tlb_entry_t             wr_entry,

    input  logic [tlb_index_w-1:0] rd_index,
    output tlb_entry_t             rd_entry,

    input  logic [vpn2_w-1:0]      probe_vpn2,
    input  logic [asid_w-1:0]      probe_asid,
    output logic                   probe_hit,
    output logic [tlb_index_w-1:0] probe_index
);

    tlb_entry_t entries [tlb_entries];

    logic [tlb_index_w:0]   inst_match;
    logic [tlb_index_w:0]   data_match;
    logic [tlb_index_w:0]   probe_match;
    logic [tlb_index_w-1:0] inst_idx;
    logic [tlb_index_w-1:0] data_idx;

    // fully associative search returning {hit, index}
    function automatic logic [tlb_index_w:0] find(
        input logic [vpn2_w-1:0] vpn2,
        input logic [asid_w-1:0] asid
    );
        logic [tlb_index_w:0] res;
        res = '0;
        // scan downwards so the lowest match is left standing
        for (int i = tlb_entries - 1; i >= 0; i--) begin
            if (entries[i].vpn2 == vpn2 && (entries[i].g || entries[i].asid == asid)) begin
                res = {1'b1, tlb_index_w'(i)};
            end
        end
        return res;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // all pages invalid and nothing global
            for (int i = 0; i < tlb_entries; i++) begin
                entries[i] <= '0;
            end
        end else if (wr_en) begin
            entries[wr_index] <= wr_entry;
        end
    end

    always_comb begin
        inst_match  = find(inst_lk.vpn2, inst_lk.asid);
        data_match  = find(data_lk.vpn2, data_lk.asid);
        probe_match = find(probe_vpn2, probe_asid);
    end

    assign inst_idx = inst_match[tlb_index_w-1:0];
    assign data_idx = data_match[tlb_index_w-1:0];

    assign inst_lk.hit  = inst_match[tlb_index_w];
    assign inst_lk.page = inst_lk.odd ? entries[inst_idx].page1 : entries[inst_idx].page0;

    assign data_lk.hit  = data_match[tlb_index_w];
    assign data_lk.page = data_lk.odd ? entries[data_idx].page1 : entries[data_idx].page0;

    assign probe_hit   = probe_match[tlb_index_w];
    assign probe_index = probe_match[tlb_index_w-1:0];

    assign rd_entry = entries[rd_index];

endmodule

// File: hw/tlb_lookup_if.sv
`timescale 1ns/1ps

interface tlb_lookup_if
    import mmu_pkg::*;
();

    logic [vpn2_w-1:0] vpn2;
    logic [asid_w-1:0] asid;
    // vaddr bit 12 picks the odd page
    logic              odd;
    logic              hit;
    tlb_page_t         page;

    modport requester (
        output vpn2, asid, odd,
        input  hit, page
    );

    modport responder (
        input  vpn2, asid, odd,
        output hit, page
    );

endinterface

// File: hw/mmu_pkg.sv
package mmu_pkg;

    localparam int tlb_entries = 32;
    localparam int tlb_index_w = 5;
    localparam int vpn2_w      = 19;
    localparam int asid_w      = 8;
    localparam int pfn_w       = 20;

    typedef enum logic [2:0] {
        no_exc,
        refill_l,
        refill_s,
        invalid_l,
        invalid_s,
        modified
    } tlb_exc_t;

    typedef enum logic [1:0] {
        tlbp,
        tlbr,
        tlbwi,
        tlbwr
    } tlb_cmd_t;

    // even or odd half of an entry
    typedef struct packed {
        logic [pfn_w-1:0] pfn;
        logic [2:0]       c;
        logic             d;
        logic             v;
    } tlb_page_t;

    typedef struct packed {
        logic [vpn2_w-1:0] vpn2;
        logic [asid_w-1:0] asid;
        logic              g;
        tlb_page_t         page0;
        tlb_page_t         page1;
    } tlb_entry_t;

    // cp0 images in the architectural bit layout
    typedef struct packed {
        logic [31:0] index;
        logic [31:0] entryhi;
        logic [31:0] entrylo0;
        logic [31:0] entrylo1;
    } tlb_regs_t;

endpackage
